// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_layer
RTL_TOP   ?= conv_layer_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
RTL_SRCS  ?= hdl/conv_pkg.sv hdl/skid_buffer.sv hdl/line_window.sv hdl/weight_loader.sv \
             hdl/conv_lane.sv hdl/channel_serializer.sv hdl/conv_layer_top.sv
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the outcome
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall +incdir+hdl $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/skid_buffer.sv
hdl/line_window.sv
hdl/weight_loader.sv
hdl/conv_lane.sv
hdl/channel_serializer.sv
hdl/conv_layer_top.sv
test/tb_conv_layer.sv

// File: hdl/channel_serializer.sv
`include "conv_settings.svh"

module channel_serializer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     lane_valid,
	output logic                     lane_ready,
	input  logic signed [`ACC_W-1:0] lane_res [`CH_OUT],
	output logic                     out_valid,
	input  logic                     out_ready,
	output conv_pkg::conv_result_t   out
);

	localparam int CH_LAST = `CH_OUT - 1;

	logic signed [`ACC_W-1:0] cap [`CH_OUT];
	logic [`CH_W-1:0]         ptr;
	logic                     out_fire;
	logic                     last;
	logic                     capture;

	assign out_fire = out_valid && out_ready;
	assign last     = (ptr == `CH_W'(CH_LAST));

	// Take a new window when empty or when the last channel is leaving
	assign lane_ready = !out_valid || (out_fire && last);
	assign capture    = lane_valid && lane_ready;

	assign out.ch   = ptr;
	assign out.data = cap[ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			ptr       <= '0;
		end else begin
			if (capture) begin
				out_valid <= 1'b1;
			end else if (out_fire && last) begin
				out_valid <= 1'b0;
			end
			if (out_fire) begin
				ptr <= last ? '0 : ptr + 1'b1;
			end
		end
	end

	// Capture bank for one window
	always_ff @(posedge clk) begin
		if (capture) begin
			for (int i = 0; i < `CH_OUT; i++) begin
				cap[i] <= lane_res[i];
			end
		end
	end

endmodule

// File: hdl/conv_lane.sv
`include "conv_settings.svh"

module conv_lane (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     we,
	input  conv_pkg::weight_tap_t    tap,
	input  logic                     win_valid,
	output logic                     win_ready,
	input  conv_pkg::window_t        win,
	output logic                     res_valid,
	input  logic                     res_ready,
	output logic signed [`ACC_W-1:0] res
);

	localparam int TAPS   = `KERNEL*`KERNEL;
	localparam int PROD_W = `DATA_W + `WEIGHT_W;

	logic signed [`WEIGHT_W-1:0] coef [TAPS];
	logic signed [PROD_W-1:0]    prod [TAPS];
	logic signed [`ACC_W-1:0]    sum;
	logic                        s1_valid;
	logic                        s1_en;
	logic                        s2_en;

	// Each stage moves when the next one is empty or draining
	assign s2_en     = !res_valid || res_ready;
	assign s1_en     = !s1_valid || s2_en;
	assign win_ready = s1_en;

	//////////////////////////////////////////////////////////////////////
	// Kernel weights, written by tap index
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < TAPS; i++) begin
				coef[i] <= '0;
			end
		end else if (we) begin
			coef[tap.idx] <= tap.w;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 1: products
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else if (s1_en) begin
			s1_valid <= win_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_en && win_valid) begin
			for (int i = 0; i < TAPS; i++) begin
				prod[i] <= win[i] * coef[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2: sum at full width
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		sum = '0;
		for (int i = 0; i < TAPS; i++) begin
			sum = sum + prod[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else if (s2_en) begin
			res_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s2_en && s1_valid) begin
			res <= sum;
		end
	end

endmodule

// File: hdl/conv_layer_top.sv
`include "conv_settings.svh"

module conv_layer_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        pix_valid,
	output logic                        pix_ready,
	input  conv_pkg::pixel_beat_t       pix,
	input  logic                        weight_valid,
	input  logic signed [`WEIGHT_W-1:0] weight,
	output logic                        res_valid,
	input  logic                        res_ready,
	output conv_pkg::conv_result_t      res
);
	import conv_pkg::*;

	pixel_beat_t              pix_q;
	logic                     pix_q_valid;
	logic                     pix_q_ready;
	window_t                  win;
	logic                     win_valid;
	logic [`CH_OUT-1:0]       win_ready;
	logic [`CH_OUT-1:0]       lane_we;
	weight_tap_t              tap;
	logic [`CH_OUT-1:0]       lane_valid;
	logic                     lane_ready;
	logic signed [`ACC_W-1:0] lane_res [`CH_OUT];
	conv_result_t             ser_out;
	logic                     ser_valid;
	logic                     ser_ready;

	skid_buffer #(.payload_t(pixel_beat_t)) u_pix_skid (
		.clk      (clk),
		.reset    (reset),
		.in_valid (pix_valid),
		.in_ready (pix_ready),
		.in_data  (pix),
		.out_valid(pix_q_valid),
		.out_ready(pix_q_ready),
		.out_data (pix_q)
	);

	// Lanes run in lockstep, so lane 0 speaks for all of them
	line_window u_line_window (
		.clk      (clk),
		.reset    (reset),
		.pix_valid(pix_q_valid),
		.pix_ready(pix_q_ready),
		.pix      (pix_q),
		.win_valid(win_valid),
		.win_ready(win_ready[0]),
		.win      (win)
	);

	weight_loader u_weight_loader (
		.clk         (clk),
		.reset       (reset),
		.weight_valid(weight_valid),
		.weight      (weight),
		.lane_we     (lane_we),
		.tap         (tap)
	);

	for (genvar i = 0; i < `CH_OUT; i++) begin : g_lane
		conv_lane u_conv_lane (
			.clk      (clk),
			.reset    (reset),
			.we       (lane_we[i]),
			.tap      (tap),
			.win_valid(win_valid),
			.win_ready(win_ready[i]),
			.win      (win),
			.res_valid(lane_valid[i]),
			.res_ready(lane_ready),
			.res      (lane_res[i])
		);
	end

	channel_serializer u_channel_serializer (
		.clk       (clk),
		.reset     (reset),
		.lane_valid(lane_valid[0]),
		.lane_ready(lane_ready),
		.lane_res  (lane_res),
		.out_valid (ser_valid),
		.out_ready (ser_ready),
		.out       (ser_out)
	);

	skid_buffer #(.payload_t(conv_result_t)) u_res_skid (
		.clk      (clk),
		.reset    (reset),
		.in_valid (ser_valid),
		.in_ready (ser_ready),
		.in_data  (ser_out),
		.out_valid(res_valid),
		.out_ready(res_ready),
		.out_data (res)
	);

endmodule

// File: hdl/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

	// Tap index width, enough for KERNEL x KERNEL taps
	localparam int TAP_W = 4;

	// Named so that elements of a window keep their sign
	typedef logic signed [`DATA_W-1:0] pixel_t;

	typedef struct packed {
		logic   sof;
		pixel_t data;
	} pixel_beat_t;

	// Row-major, oldest row first, oldest column first
	typedef pixel_t [0:`KERNEL*`KERNEL-1] window_t;

	typedef struct packed {
		logic [TAP_W-1:0]            idx;
		logic signed [`WEIGHT_W-1:0] w;
	} weight_tap_t;

	typedef struct packed {
		logic [`CH_W-1:0]         ch;
		logic signed [`ACC_W-1:0] data;
	} conv_result_t;

endpackage

// File: hdl/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Image and kernel geometry
//////////////////////////////////////////////////////////////////////
`define IMG_W    16
`define KERNEL   3
`define COL_W    4

//////////////////////////////////////////////////////////////////////
// Datapath widths and lane count
//////////////////////////////////////////////////////////////////////
`define DATA_W   8
`define WEIGHT_W 8
// Nine 16-bit products fit in 20 bits
`define ACC_W    20
`define CH_OUT   4
`define CH_W     2

`endif

// File: hdl/line_window.sv
`include "conv_settings.svh"

module line_window (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pix_valid,
	output logic                  pix_ready,
	input  conv_pkg::pixel_beat_t pix,
	output logic                  win_valid,
	input  logic                  win_ready,
	output conv_pkg::window_t     win
);
	import conv_pkg::*;

	localparam int ROW_W = $clog2(`KERNEL);

	pixel_t            row1 [`IMG_W];
	pixel_t            row2 [`IMG_W];
	pixel_t            new_col [`KERNEL];
	logic [`COL_W-1:0] col_cnt;
	logic [ROW_W-1:0]  row_cnt;
	logic [`COL_W-1:0] cur_col;
	logic [ROW_W-1:0]  cur_row;
	logic              pix_fire;
	logic              interior;

	assign pix_ready = !win_valid || win_ready;
	assign pix_fire  = pix_valid && pix_ready;

	// Position of the incoming pixel, sof forces the origin
	assign cur_col  = pix.sof ? '0 : col_cnt;
	assign cur_row  = pix.sof ? '0 : row_cnt;
	assign interior = (cur_col >= `COL_W'(`KERNEL-1)) && (cur_row == ROW_W'(`KERNEL-1));

	// Column entering the window, oldest row first
	assign new_col[0] = row2[cur_col];
	assign new_col[1] = row1[cur_col];
	assign new_col[2] = pix.data;

	//////////////////////////////////////////////////////////////////////
	// Row and column tracking
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pix_fire) begin
			if (cur_col == `COL_W'(`IMG_W-1)) begin
				col_cnt <= '0;
				// Row count saturates once the window is tall enough
				row_cnt <= (cur_row == ROW_W'(`KERNEL-1)) ? cur_row : cur_row + 1'b1;
			end else begin
				col_cnt <= cur_col + 1'b1;
				row_cnt <= cur_row;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Line buffers and window shift register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (pix_fire) begin
			row1[cur_col] <= pix.data;
			row2[cur_col] <= row1[cur_col];
			for (int r = 0; r < `KERNEL; r++) begin
				for (int c = 0; c < `KERNEL-1; c++) begin
					win[r*`KERNEL+c] <= win[r*`KERNEL+c+1];
				end
				win[r*`KERNEL+`KERNEL-1] <= new_col[r];
			end
		end
	end

	// Edge positions shift the window but never present it
	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else if (pix_ready) begin
			win_valid <= pix_fire && interior;
		end
	end

endmodule

// File: hdl/skid_buffer.sv
module skid_buffer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     skid_valid;
	payload_t skid_data;
	logic     out_free;

	// Output register can take a new beat this cycle
	assign out_free = out_ready || !out_valid;

	// Ready only looks at the skid register
	assign in_ready = !skid_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			out_valid  <= skid_valid || in_valid;
			skid_valid <= 1'b0;
		end else if (in_valid && !skid_valid) begin
			// Output stalled, park the incoming beat
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			out_data <= skid_valid ? skid_data : in_data;
		end
		if (!out_free && !skid_valid && in_valid) begin
			skid_data <= in_data;
		end
	end

endmodule

// File: hdl/weight_loader.sv
`include "conv_settings.svh"

module weight_loader (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        weight_valid,
	input  logic signed [`WEIGHT_W-1:0] weight,
	output logic [`CH_OUT-1:0]          lane_we,
	output conv_pkg::weight_tap_t       tap
);
	import conv_pkg::*;

	localparam int TAP_LAST  = `KERNEL*`KERNEL - 1;
	localparam int LANE_LAST = `CH_OUT - 1;

	logic [TAP_W-1:0] tap_cnt;
	logic [`CH_W-1:0] lane_cnt;

	//////////////////////////////////////////////////////////////////////
	// Tap and lane counters, one step per weight beat
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_cnt  <= '0;
			lane_cnt <= '0;
			lane_we  <= '0;
		end else begin
			lane_we <= '0;
			if (weight_valid) begin
				lane_we[lane_cnt] <= 1'b1;
				if (tap_cnt == TAP_W'(TAP_LAST)) begin
					tap_cnt  <= '0;
					lane_cnt <= (lane_cnt == `CH_W'(LANE_LAST)) ? '0 : lane_cnt + 1'b1;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

	// Shared by all lanes, only the enabled lane writes it
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			tap.idx <= tap_cnt;
			tap.w   <= weight;
		end
	end

endmodule

// File: test/tb_conv_layer.sv
`include "conv_settings.svh"

module tb_conv_layer;
	timeunit 1ns;
	timeprecision 100ps;
	import conv_pkg::*;

	localparam int SEED     = 74;
	localparam int TAPS     = `KERNEL * `KERNEL;
	localparam int MAX_ROWS = 8;
	localparam int F1_ROWS  = 6;
	localparam int F1_TAIL  = `IMG_W;
	// Short frame, its last row stops part way
	localparam int F2_ROWS  = 5;
	localparam int F2_TAIL  = 9;
	localparam int F3_ROWS  = 4;
	localparam int F3_TAIL  = `IMG_W;
	// Cycles without a result before the drain gives up
	localparam int DRAIN_IDLE = 200;

	logic                        clk = 1'b0;
	logic                        reset;
	logic                        pix_valid;
	logic                        pix_ready;
	pixel_beat_t                 pix;
	logic                        weight_valid;
	logic signed [`WEIGHT_W-1:0] weight;
	logic                        res_valid;
	logic                        res_ready;
	conv_result_t                res;

	int                          seed = SEED;
	int                          ready_seed = SEED + 1;
	bit                          stall_on = 1'b0;
	bit                          pix_started = 1'b0;
	logic                        pix_taken = 1'b0;
	int                          cycles = 0;
	int                          limit;
	int                          n_results = 0;
	int                          value_errors = 0;
	int                          count_errors = 0;
	conv_result_t                exp_r;
	conv_result_t                exp_q [$];
	pixel_t                      img [MAX_ROWS][`IMG_W];
	logic signed [`WEIGHT_W-1:0] w_model [`CH_OUT][TAPS];

	conv_layer_top u_conv_layer_top (
		.clk         (clk),
		.reset       (reset),
		.pix_valid   (pix_valid),
		.pix_ready   (pix_ready),
		.pix         (pix),
		.weight_valid(weight_valid),
		.weight      (weight),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic int frame_pixels(input int rows, input int tail);
		return (rows - 1) * `IMG_W + tail;
	endfunction

	// Interior windows only, the last row may be short
	function automatic int frame_results(input int rows, input int tail);
		int windows;
		windows = (rows - `KERNEL) * (`IMG_W - `KERNEL + 1);
		if (tail >= `KERNEL) begin
			windows = windows + tail - `KERNEL + 1;
		end
		return windows * `CH_OUT;
	endfunction

	// Expected results in raster order, channel 0 first
	task automatic queue_expected(input int npix);
		int           row;
		int           col;
		int           acc;
		conv_result_t r;
		for (int p = 0; p < npix; p++) begin
			row = p / `IMG_W;
			col = p % `IMG_W;
			if (row >= `KERNEL - 1 && col >= `KERNEL - 1) begin
				for (int ch = 0; ch < `CH_OUT; ch++) begin
					acc = 0;
					for (int i = 0; i < `KERNEL; i++) begin
						for (int j = 0; j < `KERNEL; j++) begin
							acc = acc + int'(img[row - `KERNEL + 1 + i][col - `KERNEL + 1 + j])
								* int'(w_model[ch][i * `KERNEL + j]);
						end
					end
					r.ch   = `CH_W'(ch);
					r.data = `ACC_W'(acc);
					exp_q.push_back(r);
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	// Beat n goes to lane n / 9, tap n % 9
	task automatic load_weights();
		int n;
		n = 0;
		while (n < TAPS * `CH_OUT) begin
			@(negedge clk);
			weight_valid = ($random(seed) & 3) != 0;
			if (weight_valid) begin
				weight = `WEIGHT_W'($random(seed));
				w_model[n / TAPS][n % TAPS] = weight;
				n++;
			end
		end
		@(negedge clk);
		weight_valid = 1'b0;
	endtask

	// Holds each beat until it is taken, random gaps between beats
	task automatic drive_pixels(input int npix);
		int p;
		p = 0;
		while (p < npix || pix_valid) begin
			@(negedge clk);
			if (!pix_valid || pix_taken) begin
				pix_valid = 1'b0;
				if (p < npix && ($random(seed) & 3) != 0) begin
					pix_valid   = 1'b1;
					pix.sof     = (p == 0);
					pix.data    = img[p / `IMG_W][p % `IMG_W];
					pix_started = 1'b1;
					p++;
				end
			end
		end
	endtask

	task automatic send_frame(input int rows, input int tail);
		int npix;
		npix = frame_pixels(rows, tail);
		for (int p = 0; p < npix; p++) begin
			img[p / `IMG_W][p % `IMG_W] = `DATA_W'($random(seed));
		end
		queue_expected(npix);
		drive_pixels(npix);
	endtask

	// Waits for the queue to empty or for the results to stop coming
	task automatic drain_results();
		int idle;
		int seen;
		idle = 0;
		seen = n_results;
		while (exp_q.size() != 0 && idle < DRAIN_IDLE) begin
			@(negedge clk);
			if (n_results != seen) begin
				seen = n_results;
				idle = 0;
			end else begin
				idle++;
			end
		end
		// A few more cycles to catch extra results
		repeat (20) @(negedge clk);
	endtask

	task automatic check_count(input int expected, input string what);
		if (n_results != expected) begin
			$display("Result count after %s is %0d, expected %0d", what, n_results, expected);
			count_errors++;
		end
	endtask

	// Random back-pressure on the result port
	initial begin
		res_ready = 1'b1;
		forever begin
			@(negedge clk);
			res_ready = stall_on ? (($random(ready_seed) & 1) != 0) : 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Monitor and scoreboard
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		pix_taken <= pix_valid && pix_ready;
		if (!reset && res_valid && !pix_started) begin
			$display("A result was valid before any pixel was sent");
			value_errors++;
		end
		if (!reset && res_valid && res_ready) begin
			n_results++;
			if (exp_q.size() == 0) begin
				$display("Extra result on channel %0d with nothing expected", res.ch);
				value_errors++;
			end else begin
				exp_r = exp_q.pop_front();
				if (res.ch !== exp_r.ch) begin
					$display("ERROR: res.ch = 0x%0h, expected 0x%0h (result %0d)",
						res.ch, exp_r.ch, n_results);
					value_errors++;
				end
				if (res.data !== exp_r.data) begin
					$display("ERROR: res.data = 0x%0h, expected 0x%0h (result %0d)",
						res.data, exp_r.data, n_results);
					value_errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Run stopped after %0d cycles with %0d expected results outstanding",
				limit, exp_q.size());
			$display("Summary: %0d results, %0d value errors, %0d count errors",
				n_results, value_errors, count_errors);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		reset        = 1'b1;
		pix_valid    = 1'b0;
		pix          = '0;
		weight_valid = 1'b0;
		weight       = '0;
		limit = 4 * (frame_pixels(F1_ROWS, F1_TAIL) + frame_pixels(F2_ROWS, F2_TAIL)
			+ frame_pixels(F3_ROWS, F3_TAIL) + frame_results(F1_ROWS, F1_TAIL)
			+ frame_results(F2_ROWS, F2_TAIL) + frame_results(F3_ROWS, F3_TAIL)) + 1000;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// Idle and weights only, no result may show up
		repeat (8) @(negedge clk);
		load_weights();
		repeat (8) @(negedge clk);

		stall_on = 1'b1;
		send_frame(F1_ROWS, F1_TAIL);
		send_frame(F2_ROWS, F2_TAIL);
		drain_results();
		check_count(frame_results(F1_ROWS, F1_TAIL) + frame_results(F2_ROWS, F2_TAIL),
			"the first two frames");

		// New weights between frames
		load_weights();
		repeat (4) @(negedge clk);
		send_frame(F3_ROWS, F3_TAIL);
		drain_results();
		check_count(frame_results(F1_ROWS, F1_TAIL) + frame_results(F2_ROWS, F2_TAIL)
			+ frame_results(F3_ROWS, F3_TAIL), "the third frame");

		if (exp_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_q.size());
			count_errors++;
		end
		$display("Summary: %0d results, %0d value errors, %0d count errors",
			n_results, value_errors, count_errors);
		if (value_errors == 0 && count_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
